//--- source/bpu_macros.svh
// Sizing constants for the branch prediction fetch unit.
// BPU_XLEN, BPU_BTB_IDX_W and BPU_HIST_W set the widths that every other
// width is built from. Fetch addresses are word aligned, so bits [1:0] are
// never used for table indexing.

`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// Address width
`define BPU_XLEN      32
// BTB index bits, taken from PC[BPU_BTB_IDX_W+1:2]
`define BPU_BTB_IDX_W 6
// Global history width, also the PHT index width
`define BPU_HIST_W    4
// Tag is what is left above the index and the byte offset
`define BPU_TAG_W     (`BPU_XLEN - `BPU_BTB_IDX_W - 2)
// Credits held after reset, also the upper bound
`define BPU_CREDITS   4
`define BPU_RESET_PC  32'h0000_0000

`endif

//--- source/bpu_port_pkg.sv
// Types seen on the top-level ports of the fetch unit.
// Resolve packets must carry the prediction fields exactly as they were
// issued on the fetch port, or redirects will fire spuriously.

`include "bpu_macros.svh"

package bpu_port_pkg;

    // Branch kind reported at resolve
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_JAL  = 2'd2,
        BR_JALR = 2'd3
    } br_kind_e;

    // One issued fetch and its prediction
    typedef struct packed {
        logic                 valid;
        logic [`BPU_XLEN-1:0] pc;
        logic                 btb_hit;
        logic                 pred_taken;
        logic [`BPU_XLEN-1:0] pred_target;
    } fetch_req_t;

    // Outcome of a correct-path fetch, in fetch order
    typedef struct packed {
        logic                 valid;
        logic [`BPU_XLEN-1:0] pc;
        br_kind_e             kind;
        logic                 taken;
        logic [`BPU_XLEN-1:0] target;
        // Echo of the fetch-time prediction
        logic                 btb_hit;
        logic                 pred_taken;
        logic [`BPU_XLEN-1:0] pred_target;
    } resolve_t;

    // Fetch restart request
    typedef struct packed {
        logic                 valid;
        logic [`BPU_XLEN-1:0] pc;
    } redirect_t;

endpackage

//--- source/bpu_table_pkg.sv
// Types held inside the prediction tables.
// Counter encoding is ordered so that the upper half means taken.

`include "bpu_macros.svh"

package bpu_table_pkg;

    // Two-bit saturating counter states
    typedef enum logic [1:0] {
        STRONG_NT = 2'd0,
        WEAK_NT   = 2'd1,
        WEAK_T    = 2'd2,
        STRONG_T  = 2'd3
    } ctr_state_e;

    // One direct-mapped BTB line
    typedef struct packed {
        logic                  valid;
        logic [`BPU_TAG_W-1:0] tag;
        logic [`BPU_XLEN-1:0]  target;
        // Jumps are predicted taken regardless of the counter
        logic                  uncond;
    } btb_entry_t;

endpackage

//--- source/fetch_pc_gen.sv
// PC sequencing with credit flow control.
// One fetch is issued per cycle while credits remain; at zero credits the
// PC holds. A redirect seen while no credit is left is kept until the next
// issue. Table lookups for the PC being issued are combinational.

`include "bpu_macros.svh"

module fetch_pc_gen
    import bpu_port_pkg::*;
    import bpu_table_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 credit_i,
    input  redirect_t            redirect_i,
    input  logic                 btb_hit_i,
    input  logic                 btb_uncond_i,
    input  logic [`BPU_XLEN-1:0] btb_target_i,
    input  ctr_state_e           ctr_i,
    output logic [`BPU_XLEN-1:0] lookup_pc_o,
    output fetch_req_t           fetch_o
);

    localparam int CNT_W = $clog2(`BPU_CREDITS + 1);

    logic [CNT_W-1:0]     credit_cnt_q;
    redirect_t            pend_q;
    logic                 issue;
    logic                 pred_taken;
    logic [`BPU_XLEN-1:0] pred_target;

    // Registered fetch port
    logic                 fetch_valid_q;
    logic [`BPU_XLEN-1:0] fetch_pc_q;
    logic                 fetch_hit_q;
    logic                 fetch_taken_q;
    logic [`BPU_XLEN-1:0] fetch_target_q;

    assign issue = (credit_cnt_q != '0);

    // Live redirect first, then a held one, else follow the last prediction
    assign lookup_pc_o = redirect_i.valid ? redirect_i.pc :
                         pend_q.valid     ? pend_q.pc     : fetch_target_q;

    assign pred_taken  = btb_hit_i & (btb_uncond_i | (ctr_i inside {WEAK_T, STRONG_T}));
    assign pred_target = pred_taken ? btb_target_i : lookup_pc_o + `BPU_XLEN'(4);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            credit_cnt_q  <= CNT_W'(`BPU_CREDITS);
            // Reset PC enters as a held redirect
            pend_q        <= '{valid: 1'b1, pc: `BPU_RESET_PC};
            fetch_valid_q <= 1'b0;
        end else begin
            credit_cnt_q  <= credit_cnt_q - CNT_W'(issue) + CNT_W'(credit_i);
            fetch_valid_q <= issue;
            if (issue) begin
                pend_q.valid <= 1'b0;
            end else if (redirect_i.valid) begin
                pend_q <= redirect_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            fetch_pc_q     <= lookup_pc_o;
            fetch_hit_q    <= btb_hit_i;
            fetch_taken_q  <= pred_taken;
            fetch_target_q <= pred_target;
        end
    end

    assign fetch_o = '{
        valid:       fetch_valid_q,
        pc:          fetch_pc_q,
        btb_hit:     fetch_hit_q,
        pred_taken:  fetch_taken_q,
        pred_target: fetch_target_q
    };

endmodule

//--- source/gshare_pht.sv
// Gshare direction predictor.
// Read and training both index with PC[HIST_W+1:2] XOR the current global
// history, so a resolve sees the history as it stands at resolve time.
// Only conditional branches train the counters and shift the history.

`include "bpu_macros.svh"

module gshare_pht
    import bpu_table_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [`BPU_XLEN-1:0] lookup_pc_i,
    input  logic                 update_i,
    input  logic [`BPU_XLEN-1:0] update_pc_i,
    input  logic                 taken_i,
    output ctr_state_e           ctr_o
);

    localparam int HIST_W = `BPU_HIST_W;
    localparam int DEPTH  = 2 ** HIST_W;

    logic [HIST_W-1:0] hist_q;
    ctr_state_e        pht_q [DEPTH];
    logic [HIST_W-1:0] rd_idx;
    logic [HIST_W-1:0] wr_idx;

    // One step toward the outcome, saturating at the ends
    function automatic ctr_state_e ctr_step(ctr_state_e cur, logic taken);
        ctr_state_e nxt;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            default:   nxt = taken ? STRONG_T : WEAK_T;
        endcase
        return nxt;
    endfunction

    assign rd_idx = lookup_pc_i[HIST_W+1:2] ^ hist_q;
    assign wr_idx = update_pc_i[HIST_W+1:2] ^ hist_q;
    assign ctr_o  = pht_q[rd_idx];

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            hist_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                pht_q[i] <= WEAK_NT;
            end
        end else if (update_i) begin
            pht_q[wr_idx] <= ctr_step(pht_q[wr_idx], taken_i);
            // Newest outcome enters at bit 0
            hist_q <= {hist_q[HIST_W-2:0], taken_i};
        end
    end

endmodule

//--- source/branch_target_buffer.sv
// Direct-mapped branch target buffer with full tags.
// A write replaces whatever line sits at the index; there is no
// invalidate path other than reset.

`include "bpu_macros.svh"

module branch_target_buffer
    import bpu_table_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [`BPU_XLEN-1:0] lookup_pc_i,
    input  logic                 write_i,
    input  logic [`BPU_XLEN-1:0] write_pc_i,
    input  logic [`BPU_XLEN-1:0] write_target_i,
    input  logic                 write_uncond_i,
    output logic                 hit_o,
    output logic                 uncond_o,
    output logic [`BPU_XLEN-1:0] target_o
);

    localparam int IDX_W = `BPU_BTB_IDX_W;
    localparam int DEPTH = 2 ** IDX_W;

    btb_entry_t       btb_q [DEPTH];
    btb_entry_t       rd_entry;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx   = lookup_pc_i[IDX_W+1:2];
    assign wr_idx   = write_pc_i[IDX_W+1:2];
    assign rd_entry = btb_q[rd_idx];

    assign hit_o    = rd_entry.valid && (rd_entry.tag == lookup_pc_i[`BPU_XLEN-1:IDX_W+2]);
    assign uncond_o = rd_entry.uncond;
    assign target_o = rd_entry.target;

    // Only the valid bits are cleared
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                btb_q[i].valid <= 1'b0;
            end
        end else if (write_i) begin
            btb_q[wr_idx] <= '{
                valid:  1'b1,
                tag:    write_pc_i[`BPU_XLEN-1:IDX_W+2],
                target: write_target_i,
                uncond: write_uncond_i
            };
        end
    end

endmodule

//--- source/branch_resolve.sv
// Branch decision at resolve.
// Compares the real next PC against the echoed pred_target, so a BTB miss
// on a taken branch and a wrong direction are caught the same way.
// Purely combinational.

`include "bpu_macros.svh"

module branch_resolve
    import bpu_port_pkg::*;
(
    input  resolve_t             resolve_i,
    output redirect_t            redirect_o,
    output logic                 pht_update_o,
    output logic                 btb_write_o,
    output logic                 btb_uncond_o,
    output logic [`BPU_XLEN-1:0] actual_next_o
);

    logic is_branch;
    logic taken;

    assign is_branch = (resolve_i.kind != BR_NONE);

    // BR_NONE never counts as taken
    assign taken = is_branch & resolve_i.taken;

    assign actual_next_o = taken ? resolve_i.target : resolve_i.pc + `BPU_XLEN'(4);

    assign redirect_o.valid = resolve_i.valid && (actual_next_o != resolve_i.pred_target);
    assign redirect_o.pc    = actual_next_o;

    // Counters and history train on conditional branches only
    assign pht_update_o = resolve_i.valid && (resolve_i.kind == BR_COND);

    // Targets are learned from any taken control transfer
    assign btb_write_o  = resolve_i.valid && taken;
    assign btb_uncond_o = resolve_i.kind inside {BR_JAL, BR_JALR};

endmodule

//--- source/branch_fetch_unit.sv
// Branch prediction fetch unit, top level.
// The consumer returns one credit per fetch received, discarded ones
// included, and resolves correct-path fetches in order.

`include "bpu_macros.svh"

module branch_fetch_unit
    import bpu_port_pkg::*;
    import bpu_table_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       credit_i,
    input  resolve_t   resolve_i,
    output fetch_req_t fetch_o
);

    logic [`BPU_XLEN-1:0] lookup_pc;
    logic                 btb_hit;
    logic                 btb_uncond;
    logic [`BPU_XLEN-1:0] btb_target;
    ctr_state_e           ctr;
    redirect_t            redirect;
    logic                 pht_update;
    logic                 btb_write;
    logic                 btb_write_uncond;
    logic [`BPU_XLEN-1:0] actual_next;

    fetch_pc_gen u_fetch_pc_gen (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .credit_i     (credit_i),
        .redirect_i   (redirect),
        .btb_hit_i    (btb_hit),
        .btb_uncond_i (btb_uncond),
        .btb_target_i (btb_target),
        .ctr_i        (ctr),
        .lookup_pc_o  (lookup_pc),
        .fetch_o      (fetch_o)
    );

    gshare_pht u_gshare_pht (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .lookup_pc_i (lookup_pc),
        .update_i    (pht_update),
        .update_pc_i (resolve_i.pc),
        .taken_i     (resolve_i.taken),
        .ctr_o       (ctr)
    );

    // Write target equals resolve_i.target whenever a write fires
    branch_target_buffer u_branch_target_buffer (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_pc_i    (lookup_pc),
        .write_i        (btb_write),
        .write_pc_i     (resolve_i.pc),
        .write_target_i (actual_next),
        .write_uncond_i (btb_write_uncond),
        .hit_o          (btb_hit),
        .uncond_o       (btb_uncond),
        .target_o       (btb_target)
    );

    branch_resolve u_branch_resolve (
        .resolve_i     (resolve_i),
        .redirect_o    (redirect),
        .pht_update_o  (pht_update),
        .btb_write_o   (btb_write),
        .btb_uncond_o  (btb_write_uncond),
        .actual_next_o (actual_next)
    );

endmodule

//--- bench/branch_fetch_unit_checker.sv
// Credit protocol assertions, bound into every fetch_pc_gen instance.
// CNT_W must match the width of the credit counter in fetch_pc_gen.

`include "bpu_macros.svh"

module branch_fetch_unit_checker #(
    parameter int CNT_W = 3
) (
    input logic             clk_i,
    input logic             rst_i,
    input logic [CNT_W-1:0] credit_cnt_i,
    input logic             fetch_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    a_credit_max: assert property (@(posedge clk_i) disable iff (rst_i)
        credit_cnt_i <= `BPU_CREDITS)
    else begin
        $error("credit count above its limit");
        fail_cnt++;
    end

    a_no_fetch_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        (credit_cnt_i == '0) |=> !fetch_valid_i)
    else begin
        $error("fetch presented after a zero-credit cycle");
        fail_cnt++;
    end

    // From the second edge in reset on
    a_reset_quiet: assert property (@(posedge clk_i)
        (rst_i && $past(rst_i)) |-> !fetch_valid_i)
    else begin
        $error("fetch valid during reset");
        fail_cnt++;
    end

endmodule

bind fetch_pc_gen branch_fetch_unit_checker #(.CNT_W(CNT_W)) u_checker (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .credit_cnt_i  (credit_cnt_q),
    .fetch_valid_i (fetch_valid_q)
);

//--- bench/branch_fetch_unit_tb.sv
// Random testbench for the branch prediction fetch unit.
// A hashed synthetic program fixes kind and target per word PC. A cycle
// model of credits, next PC, history, PHT and BTB predicts every fetch.
// Wrong-path fetches after a mispredict are dropped without a resolve.

`include "bpu_macros.svh"

module branch_fetch_unit_tb
    import bpu_port_pkg::*;
    import bpu_table_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FETCHES = 4000;
    localparam int MAX_CYCLES  = 200000;
    localparam int PHT_DEPTH   = 2 ** `BPU_HIST_W;
    localparam int BTB_DEPTH   = 2 ** `BPU_BTB_IDX_W;

    logic       clk_i = 1'b0;
    logic       rst_i;
    logic       credit_i;
    resolve_t   resolve_i;
    fetch_req_t fetch_o;

    integer seed = 32'hadb8_a2bc;

    // Reference model
    int                     m_credits;
    logic [`BPU_XLEN-1:0]   m_next_pc;
    logic [`BPU_HIST_W-1:0] m_hist;
    ctr_state_e             m_pht [PHT_DEPTH];
    logic                   m_btb_valid [BTB_DEPTH];
    logic [`BPU_TAG_W-1:0]  m_btb_tag [BTB_DEPTH];
    logic [`BPU_XLEN-1:0]   m_btb_target [BTB_DEPTH];
    logic                   m_btb_uncond [BTB_DEPTH];
    fetch_req_t             exp_fetch;

    // Consumer side
    fetch_req_t pending [$];
    int         outstanding;
    int         n_fetch;
    int         withhold;

    always #20 clk_i = ~clk_i;

    branch_fetch_unit u_branch_fetch_unit (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .credit_i  (credit_i),
        .resolve_i (resolve_i),
        .fetch_o   (fetch_o)
    );

    function automatic logic [31:0] prog_hash(logic [`BPU_XLEN-1:0] pc);
        logic [31:0] h;
        h = (pc >> 2) * 32'h9e37_79b1;
        return h ^ (h >> 15);
    endfunction

    // Mostly plain instructions, some branches and jumps
    function automatic br_kind_e prog_kind(logic [`BPU_XLEN-1:0] pc);
        logic [31:0] h;
        h = prog_hash(pc);
        if (h[31:28] < 4'd10) return BR_NONE;
        if (h[31:28] < 4'd13) return BR_COND;
        if (h[31:28] < 4'd15) return BR_JAL;
        return BR_JALR;
    endfunction

    // Targets stay in the low 1 KiB so that PCs come back often
    function automatic logic [`BPU_XLEN-1:0] prog_target(logic [`BPU_XLEN-1:0] pc);
        logic [31:0] h;
        h = prog_hash(pc);
        return `BPU_XLEN'({h[7:0], 2'b00});
    endfunction

    function automatic logic cond_outcome(logic [`BPU_XLEN-1:0] pc);
        logic [31:0] h;
        int          pct;
        int          r;
        h = prog_hash(pc);
        case (h[5:4])
            2'd0:    pct = 90;
            2'd1:    pct = 10;
            2'd2:    pct = 50;
            default: pct = 75;
        endcase
        r = $unsigned($random(seed)) % 100;
        return r < pct;
    endfunction

    function automatic fetch_req_t model_predict(logic [`BPU_XLEN-1:0] pc);
        fetch_req_t                f;
        logic [`BPU_BTB_IDX_W-1:0] bi;
        logic [`BPU_HIST_W-1:0]    pi;
        bi = pc[`BPU_BTB_IDX_W+1:2];
        pi = pc[`BPU_HIST_W+1:2] ^ m_hist;
        f.valid = 1'b1;
        f.pc = pc;
        f.btb_hit = m_btb_valid[bi] && (m_btb_tag[bi] == pc[`BPU_XLEN-1:`BPU_BTB_IDX_W+2]);
        f.pred_taken = f.btb_hit && (m_btb_uncond[bi] || m_pht[pi] >= WEAK_T);
        f.pred_target = f.pred_taken ? m_btb_target[bi] : pc + `BPU_XLEN'(4);
        return f;
    endfunction

    task automatic model_reset();
        m_credits = `BPU_CREDITS;
        m_next_pc = `BPU_RESET_PC;
        m_hist = '0;
        exp_fetch = '0;
        for (int i = 0; i < PHT_DEPTH; i++) begin
            m_pht[i] = WEAK_NT;
        end
        for (int i = 0; i < BTB_DEPTH; i++) begin
            m_btb_valid[i] = 1'b0;
        end
    endtask

    // One clock edge of the model, with the inputs driven for it
    task automatic model_step(logic credit, resolve_t rv, logic redir,
                              logic [`BPU_XLEN-1:0] redir_pc);
        logic [`BPU_XLEN-1:0]      pc;
        logic [`BPU_HIST_W-1:0]    pi;
        logic [`BPU_BTB_IDX_W-1:0] bi;
        int                        c;
        pc = redir ? redir_pc : m_next_pc;
        exp_fetch.valid = 1'b0;
        if (m_credits != 0) begin
            exp_fetch = model_predict(pc);
            m_next_pc = exp_fetch.pred_target;
            m_credits--;
        end else begin
            m_next_pc = pc;
        end
        if (credit) m_credits++;
        if (rv.valid && rv.kind == BR_COND) begin
            pi = rv.pc[`BPU_HIST_W+1:2] ^ m_hist;
            c = int'(m_pht[pi]);
            if (rv.taken && c < 3) c++;
            if (!rv.taken && c > 0) c--;
            m_pht[pi] = ctr_state_e'(c);
            m_hist = {m_hist[`BPU_HIST_W-2:0], rv.taken};
        end
        if (rv.valid && rv.kind != BR_NONE && rv.taken) begin
            bi = rv.pc[`BPU_BTB_IDX_W+1:2];
            m_btb_valid[bi] = 1'b1;
            m_btb_tag[bi] = rv.pc[`BPU_XLEN-1:`BPU_BTB_IDX_W+2];
            m_btb_target[bi] = rv.target;
            m_btb_uncond[bi] = (rv.kind != BR_COND);
        end
    endtask

    task automatic stop_run(string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_fetch(fetch_req_t got, fetch_req_t exp);
        if (got.valid !== exp.valid) begin
            stop_run($sformatf("FAILED at %0t ns: fetch valid %b, expected %b",
                               $time, got.valid, exp.valid));
        end else if (exp.valid && got !== exp) begin
            stop_run($sformatf({"FAILED at %0t ns: fetch pc %h hit %b taken %b target %h,",
                                " expected pc %h hit %b taken %b target %h"},
                               $time, got.pc, got.btb_hit, got.pred_taken, got.pred_target,
                               exp.pc, exp.btb_hit, exp.pred_taken, exp.pred_target));
        end
    endtask

    task automatic check_count(int got, int exp);
        if (got != exp) begin
            stop_run($sformatf("FAILED at %0t ns: outstanding fetches %0d, expected %0d",
                               $time, got, exp));
        end
    endtask

    task automatic run_cycle(input bit allow_credit, input bit allow_resolve);
        resolve_t             rv;
        fetch_req_t           head;
        logic                 credit;
        logic                 redir;
        logic [`BPU_XLEN-1:0] actual;
        @(negedge clk_i);
        if (fetch_o.valid) begin
            pending.push_back(fetch_o);
            outstanding++;
            n_fetch++;
        end
        // Fetches seen on the port against the credits the model allows
        check_count(outstanding, `BPU_CREDITS - m_credits);
        check_fetch(fetch_o, exp_fetch);
        if (u_branch_fetch_unit.u_fetch_pc_gen.u_checker.fail_cnt != 0) begin
            stop_run("An assertion on the credit logic fired");
        end
        // Occasional long credit holds, otherwise random returns
        if (withhold > 0) begin
            withhold--;
        end else if ($unsigned($random(seed)) % 64 == 0) begin
            withhold = 8 + $unsigned($random(seed)) % 16;
        end
        credit = allow_credit && withhold == 0 && outstanding > 0 && ($random(seed) & 3) != 0;
        if (credit) outstanding--;
        rv = '0;
        redir = 1'b0;
        actual = '0;
        if (allow_resolve && pending.size() > 0 && ($random(seed) & 1) != 0) begin
            head = pending.pop_front();
            rv.valid = 1'b1;
            rv.pc = head.pc;
            rv.kind = prog_kind(head.pc);
            rv.target = prog_target(head.pc);
            rv.taken = (rv.kind == BR_COND) ? cond_outcome(head.pc) : (rv.kind != BR_NONE);
            rv.btb_hit = head.btb_hit;
            rv.pred_taken = head.pred_taken;
            rv.pred_target = head.pred_target;
            actual = rv.taken ? rv.target : rv.pc + `BPU_XLEN'(4);
            if (actual != head.pred_target) begin
                redir = 1'b1;
                // All younger fetches are wrong path
                pending.delete();
            end
        end
        credit_i = credit;
        resolve_i = rv;
        model_step(credit, rv, redir, actual);
    endtask

    initial begin
        int cycles;
        rst_i = 1'b1;
        credit_i = 1'b0;
        resolve_i = '0;
        outstanding = 0;
        n_fetch = 0;
        withhold = 0;
        model_reset();
        repeat (3) begin
            @(negedge clk_i);
            check_fetch(fetch_o, exp_fetch);
        end
        rst_i = 1'b0;
        model_step(1'b0, '0, 1'b0, '0);

        cycles = 0;
        while (n_fetch < NUM_FETCHES) begin
            run_cycle(1'b1, 1'b1);
            cycles++;
            if (cycles > MAX_CYCLES) stop_run("Timeout: the fetch count never reached its target");
        end

        // Keep credits back until the unit stalls
        cycles = 0;
        while (outstanding < `BPU_CREDITS) begin
            run_cycle(1'b0, 1'b1);
            cycles++;
            if (cycles > 4 * `BPU_CREDITS) stop_run("Timeout: the unit did not stall on credits");
        end
        repeat (5) run_cycle(1'b0, 1'b1);

        if (u_branch_fetch_unit.u_fetch_pc_gen.u_checker.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- branch_fetch_unit.f
+incdir+source
source/bpu_port_pkg.sv
source/bpu_table_pkg.sv
source/fetch_pc_gen.sv
source/gshare_pht.sv
source/branch_target_buffer.sv
source/branch_resolve.sv
source/branch_fetch_unit.sv
bench/branch_fetch_unit_checker.sv
bench/branch_fetch_unit_tb.sv

//--- Bender.yml
package:
  name: branch_fetch_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/bpu_port_pkg.sv
      - source/bpu_table_pkg.sv
      - source/fetch_pc_gen.sv
      - source/gshare_pht.sv
      - source/branch_target_buffer.sv
      - source/branch_resolve.sv
      - source/branch_fetch_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/branch_fetch_unit_checker.sv
      - bench/branch_fetch_unit_tb.sv
